//--- Makefile
# Verilator build of the CAN receive monitor testbench

VERILATOR ?= verilator
TOP       ?= can_rx_tb
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sources.f

# Exit status of the simulation is the test result
run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- logic/can_bit_timing.sv
//////////////////////////////////////////////////
// Bit timing of the receive path
// Input synchronizer and falling edge detector
// Quantum prescaler and quantum counter
// Hard sync on every edge, one sample per bit
//////////////////////////////////////////////////

`timescale 1ns/1ns

module can_bit_timing #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                 clk_i,
  input  logic                 rst,
  input  logic                 rx_i,
  input  can_pkg::can_timing_t timing_i,
  output can_pkg::can_bit_t    sample_o
);

  logic [SYNC_STAGES-1:0] sync_q;
  logic                   rx_prev_q;
  logic                   rx_sync;
  logic                   hard_sync;
  logic [5:0]             presc_q;
  logic [4:0]             tq_q;
  logic                   tq_tick;
  logic                   sample_pt;
  logic                   bit_end;

  assign rx_sync   = sync_q[SYNC_STAGES-1];
  // Recessive to dominant transition on the synchronized line
  assign hard_sync = rx_prev_q & ~rx_sync;
  assign tq_tick   = (presc_q == timing_i.brp);
  // Quantum 0 is the sync segment, so tseg1 ends at quantum tseg1+1
  assign sample_pt = tq_tick && (tq_q == {1'b0, timing_i.tseg1} + 5'd1);
  assign bit_end   = tq_tick &&
                     (tq_q == {1'b0, timing_i.tseg1} + {2'b00, timing_i.tseg2} + 5'd2);

  //////////////////////////////////////////////////
  // Synchronizer, idle bus is recessive
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      sync_q    <= '1;
      rx_prev_q <= 1'b1;
    end
    else
    begin
      sync_q[0] <= rx_i;
      for (int i = 1; i < SYNC_STAGES; i++)
      begin
        sync_q[i] <= sync_q[i-1];
      end
      rx_prev_q <= rx_sync;
    end
  end

  //////////////////////////////////////////////////
  // Prescaler, quantum counter and sample strobe
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      presc_q  <= '0;
      tq_q     <= '0;
      sample_o <= '0;
    end
    else
    begin
      sample_o.valid <= 1'b0;
      if (hard_sync)
      begin
        // Edge restarts the bit at the sync segment
        presc_q <= '0;
        tq_q    <= '0;
      end
      else if (tq_tick)
      begin
        presc_q <= '0;
        tq_q    <= bit_end ? 5'd0 : tq_q + 5'd1;
        if (sample_pt)
        begin
          sample_o.valid <= 1'b1;
          sample_o.value <= rx_sync;
        end
      end
      else
      begin
        presc_q <= presc_q + 6'd1;
      end
    end
  end

  // At most one sample per bit, never back to back
  assert property (@(posedge clk_i) disable iff (rst)
    sample_o.valid |=> !sample_o.valid);

endmodule

//--- logic/can_destuff.sv
//////////////////////////////////////////////////
// Bit destuffing
// Run length counter of equal bits
// Stuff bit removal and stuff error pulse
//////////////////////////////////////////////////

`timescale 1ns/1ns

module can_destuff (
  input  logic              clk_i,
  input  logic              rst,
  input  can_pkg::can_bit_t bit_i,
  input  logic              stuff_en_i,
  output can_pkg::can_bit_t bit_o,
  output logic              stuff_err_o
);

  logic [2:0] run_q;
  logic       last_q;
  logic       is_stuff;

  // Sixth bit after five equal ones is a stuff bit
  assign is_stuff = stuff_en_i && (run_q == 3'd5);

  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      run_q       <= '0;
      last_q      <= 1'b1;
      bit_o       <= '0;
      stuff_err_o <= 1'b0;
    end
    else
    begin
      bit_o.valid <= 1'b0;
      stuff_err_o <= 1'b0;
      if (bit_i.valid)
      begin
        if (is_stuff && (bit_i.value == last_q))
          stuff_err_o <= 1'b1;
        else if (!is_stuff)
        begin
          bit_o.valid <= 1'b1;
          bit_o.value <= bit_i.value;
        end
        // Run counter saturates, a stuff bit starts a new run
        if (bit_i.value != last_q)
        begin
          run_q  <= 3'd1;
          last_q <= bit_i.value;
        end
        else if (run_q != 3'd7)
          run_q <= run_q + 3'd1;
      end
    end
  end

  // A dropped bit is either silent or an error, never passed on
  assert property (@(posedge clk_i) disable iff (rst)
    !(bit_o.valid && stuff_err_o));

endmodule

//--- logic/can_frame_rx.sv
//////////////////////////////////////////////////
// Standard frame decoder
// FSM from SOF through EOF, CRC-15 over SOF..data
// Form, CRC and stuff checks with recovery wait
//////////////////////////////////////////////////

`timescale 1ns/1ns

module can_frame_rx (
  input  logic                clk_i,
  input  logic                rst,
  input  can_pkg::can_bit_t   bit_i,
  input  logic                stuff_err_i,
  input  logic                reset_mode_i,
  output logic                stuff_en_o,
  output can_pkg::can_frame_t frame_o,
  output logic                frame_valid_o,
  output logic                rx_error_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ARB,
    ST_CTRL,
    ST_DATA,
    ST_CRC,
    ST_TAIL,
    ST_WAIT_IDLE
  } rx_state_e;

  localparam logic [15:0] CRC_POLY = 16'h4599;

  rx_state_e           state_q;
  logic [6:0]          cnt_q;
  can_pkg::can_crc_t   crc_q;
  can_pkg::can_crc_t   crc_rx_q;
  can_pkg::can_crc_t   crc_next;
  can_pkg::can_frame_t frame_q;
  logic                v;
  logic [3:0]          n_bytes;
  logic [6:0]          data_last;
  logic                bit_err;
  logic                fail;

  assign v         = bit_i.value;
  assign frame_o   = frame_q;
  assign crc_next  = {crc_q[13:0], 1'b0} ^ ({15{v ^ crc_q[14]}} & CRC_POLY[14:0]);
  // Payload is min(dlc,8) bytes
  assign n_bytes   = (frame_q.dlc > 4'd8) ? 4'd8 : frame_q.dlc;
  assign data_last = {n_bytes, 3'b000} - 7'd1;

  // Form and CRC checks on the current bit
  always_comb
  begin
    case (state_q)
      ST_CTRL: bit_err = (cnt_q == 7'd0) && v;
      ST_CRC:  bit_err = (cnt_q == 7'd15) && (!v || (crc_rx_q != crc_q));
      ST_TAIL: bit_err = (cnt_q != 7'd0) && !v;
      default: bit_err = 1'b0;
    endcase
  end

  assign fail = (stuff_err_i && stuff_en_o) || (bit_i.valid && bit_err);

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      state_q       <= ST_IDLE;
      cnt_q         <= '0;
      stuff_en_o    <= 1'b0;
      frame_valid_o <= 1'b0;
      rx_error_o    <= 1'b0;
    end
    else
    begin
      frame_valid_o <= 1'b0;
      rx_error_o    <= 1'b0;
      if (reset_mode_i)
      begin
        state_q    <= ST_IDLE;
        stuff_en_o <= 1'b0;
      end
      else if (fail)
      begin
        state_q    <= ST_WAIT_IDLE;
        cnt_q      <= '0;
        stuff_en_o <= 1'b0;
        rx_error_o <= 1'b1;
      end
      else if (bit_i.valid)
      begin
        cnt_q <= cnt_q + 7'd1;
        case (state_q)
          ST_IDLE:
          begin
            // Dominant bit on an idle bus is SOF
            if (!v)
            begin
              state_q    <= ST_ARB;
              cnt_q      <= '0;
              stuff_en_o <= 1'b1;
            end
          end
          ST_ARB:
          begin
            if (cnt_q == 7'd11)
            begin
              state_q <= ST_CTRL;
              cnt_q   <= '0;
            end
          end
          ST_CTRL:
          begin
            // IDE, r0, then four DLC bits
            if (cnt_q == 7'd5)
            begin
              cnt_q <= '0;
              if (!frame_q.rtr && ({frame_q.dlc[2:0], v} != 4'd0))
                state_q <= ST_DATA;
              else
                state_q <= ST_CRC;
            end
          end
          ST_DATA:
          begin
            if (cnt_q == data_last)
            begin
              state_q <= ST_CRC;
              cnt_q   <= '0;
            end
          end
          ST_CRC:
          begin
            // Bit 15 is the delimiter, stuffing ends here
            if (cnt_q == 7'd15)
            begin
              state_q    <= ST_TAIL;
              cnt_q      <= '0;
              stuff_en_o <= 1'b0;
            end
          end
          ST_TAIL:
          begin
            // ACK slot, ACK delimiter and seven EOF bits
            if (cnt_q == 7'd8)
            begin
              state_q       <= ST_IDLE;
              frame_valid_o <= 1'b1;
            end
          end
          ST_WAIT_IDLE:
          begin
            if (!v)
              cnt_q <= '0;
            else if (cnt_q == 7'd10)
              state_q <= ST_IDLE;
          end
          default: state_q <= ST_IDLE;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // Field shift registers and CRC
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (bit_i.valid)
    begin
      case (state_q)
        ST_IDLE:
        begin
          // Dominant SOF leaves a zero CRC
          frame_q <= '0;
          crc_q   <= '0;
        end
        ST_ARB:
        begin
          if (cnt_q == 7'd11)
            frame_q.rtr <= v;
          else
            frame_q.id <= {frame_q.id[9:0], v};
          crc_q <= crc_next;
        end
        ST_CTRL:
        begin
          if (cnt_q >= 7'd2)
            frame_q.dlc <= {frame_q.dlc[2:0], v};
          crc_q <= crc_next;
        end
        ST_DATA:
        begin
          // MSB first, byte 0 into the top slot
          frame_q.data[3'd7 - cnt_q[5:3]][3'd7 - cnt_q[2:0]] <= v;
          crc_q <= crc_next;
        end
        ST_CRC:
        begin
          if (cnt_q != 7'd15)
            crc_rx_q <= {crc_rx_q[13:0], v};
        end
        default:
        begin
        end
      endcase
    end
  end

endmodule

//--- logic/can_pkg.sv
//////////////////////////////////////////////////
// Shared definitions of the CAN receive monitor
// Width typedefs for bytes, addresses, id, dlc, crc
// Bit timing, bus bit and received frame structs
// Register address map of the byte port
//////////////////////////////////////////////////

package can_pkg;

  typedef logic [7:0]  can_byte_t;
  typedef logic [4:0]  can_addr_t;
  typedef logic [10:0] can_id_t;
  typedef logic [3:0]  can_dlc_t;
  typedef logic [14:0] can_crc_t;

  // One quantum is brp+1 clocks, segments are tseg+1 quanta
  typedef struct packed {
    logic [5:0] brp;
    logic [3:0] tseg1;
    logic [2:0] tseg2;
  } can_timing_t;

  // Bus bit, value 1 is recessive
  typedef struct packed {
    logic valid;
    logic value;
  } can_bit_t;

  // Standard frame, data byte 0 sits in slot 7
  typedef struct packed {
    can_id_t              id;
    logic                 rtr;
    can_dlc_t             dlc;
    can_byte_t [7:0]      data;
  } can_frame_t;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////
  typedef enum logic [4:0] {
    CONTROL     = 5'd0,
    COMMAND     = 5'd1,
    STATUS      = 5'd2,
    TIMING0     = 5'd3,
    TIMING1     = 5'd4,
    ACC_CODE    = 5'd5,
    ACC_MASK    = 5'd6,
    FRAME_COUNT = 5'd7,
    RX_ID       = 5'd8,
    RX_INFO     = 5'd9,
    RX_DATA0    = 5'd10,
    RX_DATA1    = 5'd11,
    RX_DATA2    = 5'd12,
    RX_DATA3    = 5'd13,
    RX_DATA4    = 5'd14,
    RX_DATA5    = 5'd15,
    RX_DATA6    = 5'd16,
    RX_DATA7    = 5'd17
  } can_reg_e;

endpackage

//--- logic/can_regs.sv
//////////////////////////////////////////////////
// Byte-wide register port of the monitor
// Control, timing and filter registers
// Command pulses, sticky error, frame counter
// Registered read mux and active-low interrupt
//////////////////////////////////////////////////

`timescale 1ns/1ns

module can_regs (
  input  logic                 clk_i,
  input  logic                 rst,
  input  logic                 reg_we_i,
  input  logic                 reg_re_i,
  input  can_pkg::can_addr_t   reg_addr_i,
  input  can_pkg::can_byte_t   reg_wdata_i,
  output can_pkg::can_byte_t   reg_rdata_o,
  output logic                 irq_n_o,
  output can_pkg::can_timing_t timing_o,
  output logic                 reset_mode_o,
  output can_pkg::can_byte_t   acc_code_o,
  output can_pkg::can_byte_t   acc_mask_o,
  output logic                 release_o,
  output logic                 clear_overrun_o,
  input  can_pkg::can_frame_t  frame_i,
  input  logic                 full_i,
  input  logic                 overrun_i,
  input  logic                 stored_i,
  input  logic                 rx_error_i
);

  logic               irq_en_q;
  logic               error_q;
  can_pkg::can_byte_t frame_cnt_q;
  logic               cmd_we;
  can_pkg::can_byte_t rdata;

  // COMMAND is write only, bits act as one-cycle pulses
  assign cmd_we          = reg_we_i && (reg_addr_i == can_pkg::COMMAND);
  assign release_o       = cmd_we && reg_wdata_i[0];
  assign clear_overrun_o = cmd_we && reg_wdata_i[1];
  assign irq_n_o         = ~(full_i && irq_en_q);

  //////////////////////////////////////////////////
  // Writable registers and status counters
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      reset_mode_o <= 1'b1;
      irq_en_q     <= 1'b0;
      timing_o     <= '0;
      acc_code_o   <= '0;
      acc_mask_o   <= '0;
      error_q      <= 1'b0;
      frame_cnt_q  <= '0;
      reg_rdata_o  <= '0;
    end
    else
    begin
      if (reg_we_i)
      begin
        case (can_pkg::can_reg_e'(reg_addr_i))
          can_pkg::CONTROL:
          begin
            reset_mode_o <= reg_wdata_i[0];
            irq_en_q     <= reg_wdata_i[1];
          end
          can_pkg::TIMING0:  timing_o.brp <= reg_wdata_i[5:0];
          can_pkg::TIMING1:
          begin
            timing_o.tseg1 <= reg_wdata_i[3:0];
            timing_o.tseg2 <= reg_wdata_i[6:4];
          end
          can_pkg::ACC_CODE: acc_code_o <= reg_wdata_i;
          can_pkg::ACC_MASK: acc_mask_o <= reg_wdata_i;
          default:
          begin
          end
        endcase
      end
      // New error wins over a clear in the same cycle
      if (rx_error_i)
        error_q <= 1'b1;
      else if (cmd_we && reg_wdata_i[2])
        error_q <= 1'b0;
      // Wraps at 255
      if (stored_i)
        frame_cnt_q <= frame_cnt_q + 8'd1;
      if (reg_re_i)
        reg_rdata_o <= rdata;
    end
  end

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////
  always_comb
  begin
    case (can_pkg::can_reg_e'(reg_addr_i))
      can_pkg::CONTROL:     rdata = {6'd0, irq_en_q, reset_mode_o};
      can_pkg::STATUS:      rdata = {5'd0, error_q, overrun_i, full_i};
      can_pkg::TIMING0:     rdata = {2'd0, timing_o.brp};
      can_pkg::TIMING1:     rdata = {1'b0, timing_o.tseg2, timing_o.tseg1};
      can_pkg::ACC_CODE:    rdata = acc_code_o;
      can_pkg::ACC_MASK:    rdata = acc_mask_o;
      can_pkg::FRAME_COUNT: rdata = frame_cnt_q;
      can_pkg::RX_ID:       rdata = frame_i.id[10:3];
      can_pkg::RX_INFO:     rdata = {frame_i.id[2:0], frame_i.rtr, frame_i.dlc};
      can_pkg::RX_DATA0:    rdata = frame_i.data[7];
      can_pkg::RX_DATA1:    rdata = frame_i.data[6];
      can_pkg::RX_DATA2:    rdata = frame_i.data[5];
      can_pkg::RX_DATA3:    rdata = frame_i.data[4];
      can_pkg::RX_DATA4:    rdata = frame_i.data[3];
      can_pkg::RX_DATA5:    rdata = frame_i.data[2];
      can_pkg::RX_DATA6:    rdata = frame_i.data[1];
      can_pkg::RX_DATA7:    rdata = frame_i.data[0];
      // COMMAND and unmapped addresses
      default:              rdata = '0;
    endcase
  end

endmodule

//--- logic/can_rx_buffer.sv
//////////////////////////////////////////////////
// Acceptance filter on id bits 10:3
// One-frame receive buffer with overrun flag
//////////////////////////////////////////////////

`timescale 1ns/1ns

module can_rx_buffer (
  input  logic                clk_i,
  input  logic                rst,
  input  can_pkg::can_frame_t frame_i,
  input  logic                frame_valid_i,
  input  logic                release_i,
  input  logic                clear_overrun_i,
  input  can_pkg::can_byte_t  acc_code_i,
  input  can_pkg::can_byte_t  acc_mask_i,
  output can_pkg::can_frame_t frame_o,
  output logic                full_o,
  output logic                overrun_o,
  output logic                stored_o
);

  logic accept;

  // Mask bit 1 means don't care
  assign accept = (((frame_i.id[10:3] ^ acc_code_i) & ~acc_mask_i) == 8'd0);

  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      full_o    <= 1'b0;
      overrun_o <= 1'b0;
      stored_o  <= 1'b0;
    end
    else
    begin
      stored_o <= 1'b0;
      if (clear_overrun_i)
        overrun_o <= 1'b0;
      if (release_i)
        full_o <= 1'b0;
      if (frame_valid_i && accept)
      begin
        if (full_o)
          overrun_o <= 1'b1;
        else
        begin
          full_o   <= 1'b1;
          stored_o <= 1'b1;
        end
      end
    end
  end

  // Contents survive a release and stay readable
  always_ff @(posedge clk_i)
  begin
    if (frame_valid_i && accept && !full_o)
      frame_o <= frame_i;
  end

  // Buffer only fills through a store
  assert property (@(posedge clk_i) disable iff (rst)
    $rose(full_o) |-> stored_o);

endmodule

//--- logic/can_rx_top.sv
//////////////////////////////////////////////////
// Top level of the receive-only CAN monitor
// Bit timing, destuff, frame decoder, rx buffer
// Register block beside the pipeline
//////////////////////////////////////////////////

`timescale 1ns/1ns

module can_rx_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic               clk_i,
  input  logic               rst,
  input  logic               rx_i,
  input  logic               reg_we_i,
  input  logic               reg_re_i,
  input  can_pkg::can_addr_t reg_addr_i,
  input  can_pkg::can_byte_t reg_wdata_i,
  output can_pkg::can_byte_t reg_rdata_o,
  output logic               irq_n_o
);

  // Configuration from the register block
  can_pkg::can_timing_t timing;
  logic                 reset_mode;
  can_pkg::can_byte_t   acc_code;
  can_pkg::can_byte_t   acc_mask;
  logic                 release_buf;
  logic                 clear_overrun;

  // Pipeline
  can_pkg::can_bit_t    sample;
  can_pkg::can_bit_t    rx_bit;
  logic                 stuff_en;
  logic                 stuff_err;
  can_pkg::can_frame_t  frame;
  logic                 frame_valid;
  logic                 rx_error;

  // Receive buffer status
  can_pkg::can_frame_t  buf_frame;
  logic                 full;
  logic                 overrun;
  logic                 stored;

  can_bit_timing #(
    .SYNC_STAGES(SYNC_STAGES)
  ) i_bit_timing (
    .clk_i    (clk_i),
    .rst      (rst),
    .rx_i     (rx_i),
    .timing_i (timing),
    .sample_o (sample)
  );

  can_destuff i_destuff (
    .clk_i       (clk_i),
    .rst         (rst),
    .bit_i       (sample),
    .stuff_en_i  (stuff_en),
    .bit_o       (rx_bit),
    .stuff_err_o (stuff_err)
  );

  can_frame_rx i_frame_rx (
    .clk_i         (clk_i),
    .rst           (rst),
    .bit_i         (rx_bit),
    .stuff_err_i   (stuff_err),
    .reset_mode_i  (reset_mode),
    .stuff_en_o    (stuff_en),
    .frame_o       (frame),
    .frame_valid_o (frame_valid),
    .rx_error_o    (rx_error)
  );

  can_rx_buffer i_rx_buffer (
    .clk_i           (clk_i),
    .rst             (rst),
    .frame_i         (frame),
    .frame_valid_i   (frame_valid),
    .release_i       (release_buf),
    .clear_overrun_i (clear_overrun),
    .acc_code_i      (acc_code),
    .acc_mask_i      (acc_mask),
    .frame_o         (buf_frame),
    .full_o          (full),
    .overrun_o       (overrun),
    .stored_o        (stored)
  );

  can_regs i_regs (
    .clk_i           (clk_i),
    .rst             (rst),
    .reg_we_i        (reg_we_i),
    .reg_re_i        (reg_re_i),
    .reg_addr_i      (reg_addr_i),
    .reg_wdata_i     (reg_wdata_i),
    .reg_rdata_o     (reg_rdata_o),
    .irq_n_o         (irq_n_o),
    .timing_o        (timing),
    .reset_mode_o    (reset_mode),
    .acc_code_o      (acc_code),
    .acc_mask_o      (acc_mask),
    .release_o       (release_buf),
    .clear_overrun_o (clear_overrun),
    .frame_i         (buf_frame),
    .full_i          (full),
    .overrun_i       (overrun),
    .stored_i        (stored),
    .rx_error_i      (rx_error)
  );

endmodule

//--- sim/can_rx_tb.sv
//////////////////////////////////////////////////
// Testbench of the CAN receive monitor
// LFSR stimulus and frame encoder reference
// Bus bit driver and register port tasks
// Compare tasks for bytes, frames and irq
//////////////////////////////////////////////////

`timescale 1ns/1ns

module can_rx_tb;

  localparam int BRP         = 1;
  localparam int TSEG1       = 5;
  localparam int TSEG2       = 2;
  // Clocks per bus bit
  localparam int BIT_CLKS    = (BRP + 1) * (TSEG1 + TSEG2 + 3);
  localparam int IRQ_TIMEOUT = 4 * BIT_CLKS;
  // Filter compares id bits 10:7, bits 6:3 are don't care
  localparam can_pkg::can_byte_t ACC_CODE_VAL = 8'hA5;
  localparam can_pkg::can_byte_t ACC_MASK_VAL = 8'h0F;

  logic               clk_i;
  logic               rst;
  logic               rx_i;
  logic               reg_we_i;
  logic               reg_re_i;
  can_pkg::can_addr_t reg_addr_i;
  can_pkg::can_byte_t reg_wdata_i;
  can_pkg::can_byte_t reg_rdata_o;
  logic               irq_n_o;

  // Encoded frame on the bus and position of its ACK slot
  logic               tx_bits[$];
  int                 ack_idx;
  logic [31:0]        lfsr_q;
  can_pkg::can_byte_t exp_count;

  can_rx_top #(
    .SYNC_STAGES(2)
  ) i_dut (
    .clk_i       (clk_i),
    .rst         (rst),
    .rx_i        (rx_i),
    .reg_we_i    (reg_we_i),
    .reg_re_i    (reg_re_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .irq_n_o     (irq_n_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Random numbers and reference model
  //////////////////////////////////////////////////
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic can_pkg::can_crc_t crc15_step(input can_pkg::can_crc_t crc, input logic b);
    logic fb;
    fb  = b ^ crc[14];
    crc = {crc[13:0], 1'b0};
    if (fb)
      crc = crc ^ 15'h4599;
    return crc;
  endfunction

  // Payload is min(dlc,8) bytes, none for a remote frame
  function automatic int payload_bytes(input can_pkg::can_frame_t f);
    if (f.rtr)
      return 0;
    return (f.dlc > 4'd8) ? 8 : int'(f.dlc);
  endfunction

  function automatic logic accepts(input can_pkg::can_id_t id, input can_pkg::can_byte_t code,
                                   input can_pkg::can_byte_t mask);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < 8; i++)
    begin
      // Cleared mask bit means the id bit must match the code
      if (!mask[3'(i)] && (id[4'(i + 3)] != code[3'(i)]))
        ok = 1'b0;
    end
    return ok;
  endfunction

  // Random frame, unsent data bytes stay zero
  function automatic can_pkg::can_frame_t make_frame(input logic want_accept, input logic rtr);
    can_pkg::can_frame_t f;
    f          = '0;
    f.id       = 11'(rand_bits(11));
    f.id[10:7] = want_accept ? ACC_CODE_VAL[7:4] : ~ACC_CODE_VAL[7:4];
    f.rtr      = rtr;
    f.dlc      = 4'(rand_bits(4));
    for (int k = 0; k < payload_bytes(f); k++)
      f.data[3'(7 - k)] = 8'(rand_bits(8));
    return f;
  endfunction

  // SOF through EOF with stuff bits, crc_flip corrupts the sent CRC
  function automatic void encode_frame(input can_pkg::can_frame_t f,
                                       input can_pkg::can_crc_t crc_flip);
    logic               raw[$];
    can_pkg::can_crc_t  crc;
    can_pkg::can_byte_t byte_v;
    int                 run;
    logic               last;
    raw.push_back(1'b0);
    for (int j = 0; j < 11; j++)
      raw.push_back(f.id[4'(10 - j)]);
    raw.push_back(f.rtr);
    // IDE and r0 dominant
    raw.push_back(1'b0);
    raw.push_back(1'b0);
    for (int j = 0; j < 4; j++)
      raw.push_back(f.dlc[2'(3 - j)]);
    for (int k = 0; k < payload_bytes(f); k++)
    begin
      byte_v = f.data[3'(7 - k)];
      for (int j = 0; j < 8; j++)
        raw.push_back(byte_v[3'(7 - j)]);
    end
    crc = '0;
    foreach (raw[i])
      crc = crc15_step(crc, raw[i]);
    crc = crc ^ crc_flip;
    for (int j = 0; j < 15; j++)
      raw.push_back(crc[4'(14 - j)]);
    // Stuffing covers SOF through the last CRC bit
    tx_bits.delete();
    last = 1'b1;
    run  = 0;
    foreach (raw[i])
    begin
      tx_bits.push_back(raw[i]);
      if (raw[i] == last)
        run++;
      else
      begin
        run  = 1;
        last = raw[i];
      end
      if (run == 5)
      begin
        tx_bits.push_back(~last);
        last = ~last;
        run  = 1;
      end
    end
    // CRC delimiter, ACK slot, ACK delimiter, 7 EOF bits
    tx_bits.push_back(1'b1);
    ack_idx = tx_bits.size();
    for (int j = 0; j < 9; j++)
      tx_bits.push_back(1'b1);
  endfunction

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input can_pkg::can_byte_t got,
                            input can_pkg::can_byte_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_frame(input can_pkg::can_frame_t got, input can_pkg::can_frame_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("** Error: rx frame is 0x%h, expected 0x%h", got, exp));
  endtask

  task automatic check_irq(input logic got, input logic exp);
    if (got !== exp)
      stop_with_failure($sformatf("** Error: irq_n_o is 0x%h, expected 0x%h", got, exp));
  endtask

  //////////////////////////////////////////////////
  // Bus and register port
  //////////////////////////////////////////////////
  task automatic drive_bit(input logic b);
    for (int c = 0; c < BIT_CLKS; c++)
    begin
      @(posedge clk_i);
      rx_i <= b;
    end
  endtask

  // Another node acknowledges, then the bus idles for 11 bits
  task automatic send_frame(input can_pkg::can_frame_t f, input can_pkg::can_crc_t crc_flip);
    encode_frame(f, crc_flip);
    for (int i = 0; i < tx_bits.size(); i++)
      drive_bit((i == ack_idx) ? 1'b0 : tx_bits[i]);
    for (int i = 0; i < 11; i++)
      drive_bit(1'b1);
  endtask

  task automatic write_reg(input can_pkg::can_addr_t addr, input can_pkg::can_byte_t data);
    @(posedge clk_i);
    reg_we_i    <= 1'b1;
    reg_addr_i  <= addr;
    reg_wdata_i <= data;
    @(posedge clk_i);
    reg_we_i    <= 1'b0;
  endtask

  task automatic read_reg(input can_pkg::can_addr_t addr, output can_pkg::can_byte_t data);
    @(posedge clk_i);
    reg_re_i   <= 1'b1;
    reg_addr_i <= addr;
    @(posedge clk_i);
    reg_re_i   <= 1'b0;
    // Data registered on the edge that saw reg_re_i
    @(negedge clk_i);
    data = reg_rdata_o;
  endtask

  task automatic read_check(input can_pkg::can_addr_t addr, input string name,
                            input can_pkg::can_byte_t exp);
    can_pkg::can_byte_t got;
    read_reg(addr, got);
    check_byte(name, got, exp);
  endtask

  // Only the payload of the expected frame is read back
  task automatic read_frame(input can_pkg::can_frame_t exp, output can_pkg::can_frame_t got);
    can_pkg::can_byte_t rx_id;
    can_pkg::can_byte_t info;
    can_pkg::can_byte_t d;
    got = '0;
    read_reg(can_pkg::RX_ID, rx_id);
    read_reg(can_pkg::RX_INFO, info);
    got.id  = {rx_id, info[7:5]};
    got.rtr = info[4];
    got.dlc = info[3:0];
    for (int k = 0; k < payload_bytes(exp); k++)
    begin
      read_reg(5'(int'(can_pkg::RX_DATA0) + k), d);
      got.data[3'(7 - k)] = d;
    end
  endtask

  task automatic wait_irq(input logic level);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (irq_n_o !== level)
    begin
      if (cycles == IRQ_TIMEOUT)
        stop_with_failure($sformatf("Timeout waiting for irq_n_o to become %0b", level));
      cycles++;
      @(negedge clk_i);
    end
  endtask

  // Accepted frames raise the irq and land in the buffer
  task automatic receive_and_check(input can_pkg::can_frame_t f);
    can_pkg::can_frame_t got;
    if (accepts(f.id, ACC_CODE_VAL, ACC_MASK_VAL))
    begin
      wait_irq(1'b0);
      exp_count = exp_count + 8'd1;
      read_frame(f, got);
      check_frame(got, f);
    end
    else
    begin
      @(negedge clk_i);
      check_irq(irq_n_o, 1'b1);
    end
    read_check(can_pkg::FRAME_COUNT, "FRAME_COUNT", exp_count);
  endtask

  task automatic release_buffer();
    write_reg(can_pkg::COMMAND, 8'h01);
    wait_irq(1'b1);
    read_check(can_pkg::STATUS, "STATUS", 8'h00);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial
  begin
    can_pkg::can_frame_t f1;
    can_pkg::can_frame_t f2;
    can_pkg::can_frame_t got;
    can_pkg::can_crc_t   flip;
    lfsr_q      = 32'h7e97865c;
    exp_count   = '0;
    rst         = 1'b1;
    rx_i        = 1'b1;
    reg_we_i    = 1'b0;
    reg_re_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    repeat (2) @(posedge clk_i);
    rst <= 1'b0;

    // Reset values
    @(negedge clk_i);
    check_irq(irq_n_o, 1'b1);
    read_check(can_pkg::CONTROL, "CONTROL", 8'h01);
    read_check(can_pkg::STATUS, "STATUS", 8'h00);
    read_check(can_pkg::FRAME_COUNT, "FRAME_COUNT", 8'h00);

    // Timing, filter, irq on, leave reset mode
    write_reg(can_pkg::TIMING0, 8'(BRP));
    write_reg(can_pkg::TIMING1, {1'b0, 3'(TSEG2), 4'(TSEG1)});
    write_reg(can_pkg::ACC_CODE, ACC_CODE_VAL);
    write_reg(can_pkg::ACC_MASK, ACC_MASK_VAL);
    write_reg(can_pkg::CONTROL, 8'h02);

    // Accepted data frame
    f1 = make_frame(1'b1, 1'b0);
    send_frame(f1, '0);
    receive_and_check(f1);
    release_buffer();

    // Frame rejected by the filter
    f1 = make_frame(1'b0, 1'b0);
    send_frame(f1, '0);
    receive_and_check(f1);
    read_check(can_pkg::STATUS, "STATUS", 8'h00);

    // Second frame while full sets overrun and is dropped
    f1 = make_frame(1'b1, 1'b0);
    f2 = make_frame(1'b1, 1'b0);
    send_frame(f1, '0);
    receive_and_check(f1);
    send_frame(f2, '0);
    read_check(can_pkg::STATUS, "STATUS", 8'h03);
    read_frame(f1, got);
    check_frame(got, f1);
    read_check(can_pkg::FRAME_COUNT, "FRAME_COUNT", exp_count);
    write_reg(can_pkg::COMMAND, 8'h02);
    release_buffer();

    // One corrupted CRC bit
    f1   = make_frame(1'b1, 1'b0);
    flip = 15'd1 << (int'(rand_bits(4)) % 15);
    send_frame(f1, flip);
    @(negedge clk_i);
    check_irq(irq_n_o, 1'b1);
    read_check(can_pkg::STATUS, "STATUS", 8'h04);
    read_check(can_pkg::FRAME_COUNT, "FRAME_COUNT", exp_count);
    write_reg(can_pkg::COMMAND, 8'h04);
    read_check(can_pkg::STATUS, "STATUS", 8'h00);
    f2 = make_frame(1'b1, 1'b0);
    send_frame(f2, '0);
    receive_and_check(f2);
    release_buffer();

    // Remote frame with random dlc
    f1 = make_frame(1'b1, 1'b1);
    send_frame(f1, '0);
    receive_and_check(f1);
    release_buffer();

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- sources.f
logic/can_pkg.sv
logic/can_bit_timing.sv
logic/can_destuff.sv
logic/can_frame_rx.sv
logic/can_rx_buffer.sv
logic/can_regs.sv
logic/can_rx_top.sv
sim/can_rx_tb.sv
